// ==== common/sdram_consts.svh ====
`ifndef SDRAM_CONSTS_SVH
`define SDRAM_CONSTS_SVH

//////////////////////////////
// SDRAM geometry
//////////////////////////////
`define SDRAM_BANK_BITS 2  // 4 banks
`define SDRAM_ROW_BITS 13  // 8192 rows
`define SDRAM_COL_BITS 9   // 512 columns
`define SDRAM_DATA_BITS 16

//////////////////////////////
// SDRAM timing, in clock1 cycles
//////////////////////////////
`define SDRAM_INIT_CYCLES 200        // Power-up wait, short for simulation
`define SDRAM_TRCD 2                 // ACTIVE to READ/WRITE
`define SDRAM_TRP 2                  // PRECHARGE to next command
`define SDRAM_TRFC 7                 // REFRESH to next command
`define SDRAM_CAS 2                  // CAS latency
`define SDRAM_REFRESH_INTERVAL 780   // Between auto-refreshes

//////////////////////////////
// Test and report
//////////////////////////////
`define TEST_WORDS 64        // Words per pass
`define PATTERN_SEED 16'hACE1
`define UART_DIV 16          // Cycles per serial bit

`endif

// ==== common/sdramPkg.sv ====
`default_nettype none

package sdramPkg;

    // Controller view of a word address
    typedef struct packed {
        logic [1:0]  bank;
        logic [12:0] row;
        logic [8:0]  col;
    } sdramFields_s;

    // Tester counts on flat, controller decodes fields
    typedef union packed {
        logic [23:0]  flat;
        sdramFields_s fields;
    } sdramAddr_u;

    // Bit order is {nCS, nRAS, nCAS, nWE}
    typedef enum logic [3:0] {
        NOP       = 4'b0111,
        ACTIVE    = 4'b0011,
        READ      = 4'b0101,
        WRITE     = 4'b0100,
        PRECHARGE = 4'b0010,
        REFRESH   = 4'b0001,
        LOAD_MODE = 4'b0000
    } sdramCmd_e;

    // Sent as passCount first, then errCount
    typedef struct packed {
        logic [7:0] passCount;
        logic [7:0] errCount;
    } report_s;

endpackage

`default_nettype wire

// ==== common/memReqIf.sv ====
`default_nettype none

// Call/done request path, tester to controller
interface memReqIf;

    logic [1:0]           call;   // [1] write, [0] read
    logic [1:0]           done;   // One-cycle pulse, same bit order
    sdramPkg::sdramAddr_u addr;
    logic [15:0]          wdata;
    logic [15:0]          rdata;  // Valid while done[0]

    // Holds call, addr and wdata until done
    modport requester (
        output call,
        output addr,
        output wdata,
        input  done,
        input  rdata
    );

    modport server (
        input  call,
        input  addr,
        input  wdata,
        output done,
        output rdata
    );

endinterface

`default_nettype wire

// ==== sdramCtrl/sdramCtrl.sv ====
`default_nettype none

`include "sdram_consts.svh"

module sdramCtrl (
    input  wire         clock1,
    input  wire         rst_n,
    memReqIf.server     mem,
    output logic        cke,
    output wire         nCs,
    output wire         nRas,
    output wire         nCas,
    output wire         nWe,
    output logic [12:0] addr,
    output logic [1:0]  ba,
    output wire  [1:0]  dqm,
    inout  wire  [15:0] dq
);

    localparam int CntW = $clog2(`SDRAM_INIT_CYCLES);
    localparam int RefW = $clog2(`SDRAM_REFRESH_INTERVAL);

    // Wait loads, next command lands N cycles after the current one
    localparam logic [CntW-1:0] InitLoad = CntW'(`SDRAM_INIT_CYCLES - 2);
    localparam logic [CntW-1:0] TrcdLoad = CntW'(`SDRAM_TRCD - 2);
    localparam logic [CntW-1:0] TrpLoad  = CntW'(`SDRAM_TRP - 2);
    localparam logic [CntW-1:0] TrfcLoad = CntW'(`SDRAM_TRFC - 2);
    localparam logic [CntW-1:0] CasLoad  = CntW'(`SDRAM_CAS - 1);

    // Burst length 1, sequential, CAS latency in A[6:4]
    localparam logic [12:0] ModeWord = 13'(`SDRAM_CAS) << 4;

    typedef enum logic [3:0] {
        stWait, stInitPre, stInitRef, stInitMode,
        stIdle, stRw, stCap, stPre, stDone
    } ctrlState_e;

    ctrlState_e          state;
    ctrlState_e          after;      // Where stWait goes next
    logic [CntW-1:0]     cnt;
    sdramPkg::sdramCmd_e cmd;
    logic                isWrite;    // Op of the call in flight
    logic                secondRef;  // Init refresh count
    logic                dqOe;
    logic [15:0]         dqOut;
    logic [RefW-1:0]     refCnt;
    logic                refPending;
    logic                refAck;
    sdramPkg::sdramAddr_u req;

    assign req = mem.addr;  // Decoded as bank/row/col

    assign {nCs, nRas, nCas, nWe} = cmd;
    assign dqm = 2'b00;                 // No masking
    assign dq  = dqOe ? dqOut : 16'bz;  // Driven only in the WRITE cycle

    //////////////////////////////
    // Refresh interval
    //////////////////////////////
    assign refAck = (state == stIdle) && refPending;  // IDLE issues the REFRESH

    always_ff @(posedge clock1 or negedge rst_n) begin
        if (!rst_n) begin
            refCnt     <= '0;
            refPending <= 1'b0;
        end else begin
            if (refCnt == RefW'(`SDRAM_REFRESH_INTERVAL - 1)) begin
                refCnt     <= '0;
                refPending <= 1'b1;
            end else begin
                refCnt <= refCnt + 1'b1;
                if (refAck) refPending <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // Command FSM
    //////////////////////////////
    always_ff @(posedge clock1 or negedge rst_n) begin
        if (!rst_n) begin
            state     <= stWait;     // Power-up wait first
            after     <= stInitPre;
            cnt       <= InitLoad;
            cmd       <= sdramPkg::NOP;
            cke       <= 1'b0;
            addr      <= '0;
            ba        <= '0;
            dqOe      <= 1'b0;
            isWrite   <= 1'b0;
            secondRef <= 1'b0;
            mem.done  <= 2'b00;
        end else begin
            cmd      <= sdramPkg::NOP;  // Default each cycle
            dqOe     <= 1'b0;
            mem.done <= 2'b00;
            case (state)
                stWait: begin
                    if (cnt == '0) state <= after;
                    else cnt <= cnt - 1'b1;
                end
                stInitPre: begin
                    cke      <= 1'b1;
                    cmd      <= sdramPkg::PRECHARGE;
                    addr[10] <= 1'b1;               // All banks
                    cnt      <= TrpLoad;
                    after    <= stInitRef;
                    state    <= stWait;
                end
                stInitRef: begin
                    cmd       <= sdramPkg::REFRESH;
                    secondRef <= 1'b1;
                    cnt       <= TrfcLoad;
                    after     <= secondRef ? stInitMode : stInitRef;
                    state     <= stWait;
                end
                stInitMode: begin
                    cmd   <= sdramPkg::LOAD_MODE;
                    addr  <= ModeWord;
                    ba    <= 2'b00;
                    cnt   <= '0;                    // tMRD of 2
                    after <= stIdle;
                    state <= stWait;
                end
                stIdle: begin
                    if (refPending) begin
                        cmd   <= sdramPkg::REFRESH;  // Ahead of any call
                        cnt   <= TrfcLoad;
                        after <= stIdle;
                        state <= stWait;
                    end else if (mem.call != 2'b00 && mem.done == 2'b00) begin
                        cmd     <= sdramPkg::ACTIVE;
                        ba      <= req.fields.bank;
                        addr    <= req.fields.row;
                        isWrite <= mem.call[1];
                        cnt     <= TrcdLoad;
                        after   <= stRw;
                        state   <= stWait;
                    end
                end
                stRw: begin
                    addr <= {4'b0000, req.fields.col};  // A10 low, no auto-precharge
                    if (isWrite) begin
                        cmd   <= sdramPkg::WRITE;
                        dqOe  <= 1'b1;
                        cnt   <= '0;                    // Write recovery
                        after <= stPre;
                        state <= stWait;
                    end else begin
                        cmd   <= sdramPkg::READ;
                        cnt   <= CasLoad;
                        state <= stCap;
                    end
                end
                stCap: begin
                    if (cnt == '0) begin
                        cmd   <= sdramPkg::PRECHARGE;  // Data captured this edge
                        addr  <= '0;
                        cnt   <= TrpLoad;
                        after <= stDone;
                        state <= stWait;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                stPre: begin
                    cmd   <= sdramPkg::PRECHARGE;      // Open bank only
                    addr  <= '0;
                    cnt   <= TrpLoad;
                    after <= stDone;
                    state <= stWait;
                end
                stDone: begin
                    mem.done <= isWrite ? 2'b10 : 2'b01;
                    state    <= stIdle;
                end
                default: state <= stIdle;
            endcase
        end
    end

    // Data path registers
    always_ff @(posedge clock1) begin
        if (state == stRw) dqOut <= mem.wdata;
        if (state == stCap && cnt == '0) mem.rdata <= dq;  // CAS cycles after READ
    end

endmodule

`default_nettype wire

// ==== hdl/patternGen.sv ====
`default_nettype none

`include "sdram_consts.svh"

module patternGen (
    input  wire         clock1,
    input  wire         rst_n,
    input  wire         patternStart,  // Back to seed
    input  wire         patternStep,   // One shift
    output logic [15:0] pattern
);

    logic feedback;

    // Fibonacci taps 16, 14, 13, 11
    assign feedback = pattern[15] ^ pattern[13] ^ pattern[12] ^ pattern[10];

    always_ff @(posedge clock1 or negedge rst_n) begin
        if (!rst_n) begin
            pattern <= `PATTERN_SEED;
        end else if (patternStart) begin
            pattern <= `PATTERN_SEED;              // Restart wins over step
        end else if (patternStep) begin
            pattern <= {pattern[14:0], feedback};
        end
    end

endmodule

`default_nettype wire

// ==== hdl/memTester.sv ====
`default_nettype none

`include "sdram_consts.svh"

module memTester (
    input  wire                clock1,
    input  wire                rst_n,
    memReqIf.requester         mem,
    output wire                patternStart,
    output wire                patternStep,
    input  wire  [15:0]        pattern,
    output logic               send,
    output sdramPkg::report_s  report,
    input  wire                busy,
    output logic               led
);

    typedef enum logic [2:0] {
        stStart, stWrite, stReadInit, stRead, stSend
    } testState_e;

    testState_e           state;
    sdramPkg::sdramAddr_u reqAddr;  // Flat word index
    logic [7:0]           passCount;
    logic [7:0]           errCount;
    logic                 lastWord;

    assign lastWord  = (reqAddr.flat == 24'(`TEST_WORDS - 1));
    assign mem.addr  = reqAddr;
    assign mem.wdata = pattern;     // Stable until done, steps after

    // Generator follows the phases
    assign patternStart = (state == stStart) || (state == stReadInit);
    assign patternStep  = (state == stWrite && mem.done[1]) ||
                          (state == stRead && mem.done[0]);

    always_ff @(posedge clock1 or negedge rst_n) begin
        if (!rst_n) begin
            state     <= stStart;
            reqAddr   <= '0;
            passCount <= '0;
            errCount  <= '0;
            mem.call  <= 2'b00;
            send      <= 1'b0;
            report    <= '0;
            led       <= 1'b0;
        end else begin
            send <= 1'b0;  // One-cycle pulse
            case (state)
                stStart: begin
                    reqAddr.flat <= '0;
                    errCount     <= '0;
                    state        <= stWrite;
                end
                stWrite: begin
                    if (mem.done[1]) begin
                        mem.call <= 2'b00;  // Drop for a cycle
                        if (lastWord) state <= stReadInit;
                        else reqAddr.flat <= reqAddr.flat + 1'b1;
                    end else begin
                        mem.call <= 2'b10;
                    end
                end
                stReadInit: begin
                    reqAddr.flat <= '0;
                    state        <= stRead;
                end
                stRead: begin
                    if (mem.done[0]) begin
                        mem.call <= 2'b00;
                        if (mem.rdata != pattern) begin
                            led <= 1'b1;  // Sticky
                            if (errCount != 8'hFF) errCount <= errCount + 1'b1;
                        end
                        if (lastWord) state <= stSend;
                        else reqAddr.flat <= reqAddr.flat + 1'b1;
                    end else begin
                        mem.call <= 2'b01;
                    end
                end
                stSend: begin
                    if (!busy) begin  // Previous frame gone
                        send             <= 1'b1;
                        report.passCount <= passCount;
                        report.errCount  <= errCount;
                        passCount        <= passCount + 1'b1;  // Wraps
                        state            <= stStart;
                    end
                end
                default: state <= stStart;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uartTx.sv ====
`default_nettype none

`include "sdram_consts.svh"

module uartTx (
    input  wire               clock1,
    input  wire               rst_n,
    input  wire               send,
    input  wire sdramPkg::report_s report,
    output logic              busy,
    output wire               txd
);

    localparam int DivW = $clog2(`UART_DIV);

    logic [19:0]     frame;   // Two 8N1 bytes, LSB out first
    logic [4:0]      bitIdx;
    logic [DivW-1:0] divCnt;
    logic            bitEnd;

    assign bitEnd = (divCnt == DivW'(`UART_DIV - 1));
    assign txd    = busy ? frame[0] : 1'b1;  // Idle high

    always_ff @(posedge clock1 or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            bitIdx <= '0;
            divCnt <= '0;
        end else if (!busy) begin
            busy   <= send;
            bitIdx <= '0;
            divCnt <= '0;
        end else if (bitEnd) begin
            divCnt <= '0;
            bitIdx <= bitIdx + 1'b1;
            if (bitIdx == 5'd19) busy <= 1'b0;  // Last stop bit out
        end else begin
            divCnt <= divCnt + 1'b1;
        end
    end

    // stop, errCount, start, stop, passCount, start
    always_ff @(posedge clock1) begin
        if (!busy && send) begin
            frame <= {1'b1, report.errCount, 1'b0, 1'b1, report.passCount, 1'b0};
        end else if (busy && bitEnd) begin
            frame <= {1'b1, frame[19:1]};
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sdramTestTop.sv ====
`default_nettype none

module sdramTestTop (
    input  wire        clock1,
    input  wire        rst_n,
    output wire        cke,
    output wire        nCs,
    output wire        nRas,
    output wire        nCas,
    output wire        nWe,
    output wire [12:0] addr,
    output wire [1:0]  ba,
    output wire [1:0]  dqm,
    inout  wire [15:0] dq,
    output wire        txd,
    output wire        led
);

    wire               patternStart;
    wire               patternStep;
    wire [15:0]        pattern;
    wire               send;
    wire               busy;
    sdramPkg::report_s report;

    memReqIf mem ();  // Tester to controller

    sdramCtrl uCtrl (
        .clock1 (clock1),
        .rst_n  (rst_n),
        .mem    (mem.server),
        .cke    (cke),
        .nCs    (nCs),
        .nRas   (nRas),
        .nCas   (nCas),
        .nWe    (nWe),
        .addr   (addr),
        .ba     (ba),
        .dqm    (dqm),
        .dq     (dq)
    );

    patternGen uPattern (
        .clock1       (clock1),
        .rst_n        (rst_n),
        .patternStart (patternStart),
        .patternStep  (patternStep),
        .pattern      (pattern)
    );

    memTester uTester (
        .clock1       (clock1),
        .rst_n        (rst_n),
        .mem          (mem.requester),
        .patternStart (patternStart),
        .patternStep  (patternStep),
        .pattern      (pattern),
        .send         (send),
        .report       (report),
        .busy         (busy),
        .led          (led)
    );

    uartTx uUart (
        .clock1 (clock1),
        .rst_n  (rst_n),
        .send   (send),
        .report (report),
        .busy   (busy),
        .txd    (txd)
    );

endmodule

`default_nettype wire

// ==== dv/sdramModel.sv ====
`default_nettype none

// Behavioural SDRAM, one open row, storage by bank and column
module sdramModel (
    input  wire         clock1,
    input  wire         rst_n,
    input  wire         cke,
    input  wire         nCs,
    input  wire         nRas,
    input  wire         nCas,
    input  wire         nWe,
    input  wire  [12:0] addr,
    input  wire  [1:0]  ba,
    input  wire  [1:0]  dqm,
    inout  wire  [15:0] dq,
    input  wire         stuckEn,      // Force one bit on reads
    input  wire  [3:0]  stuckBit,
    input  wire         stuckVal,
    output logic [31:0] refreshes,    // REFRESH commands seen
    output logic        earlyAccess,  // READ or WRITE before mode load
    output logic        badAccess     // No open row, or masked write
);

    sdramPkg::sdramCmd_e cmd;
    logic [15:0] words [0:2047];  // Indexed {bank, column}, tester stays in row 0
    logic        modeLoaded;
    logic        rowOpen;
    logic        rdOe;
    logic [15:0] rdData;

    // Clock disabled reads as NOP
    assign cmd = cke ? sdramPkg::sdramCmd_e'({nCs, nRas, nCas, nWe}) : sdramPkg::NOP;
    assign dq  = rdOe ? rdData : 16'bz;

    function automatic logic [15:0] forceBit(input logic [15:0] w, input logic [3:0] b,
                                             input logic v);
        logic [15:0] r;
        r    = w;
        r[b] = v;
        return r;
    endfunction

    //////////////////////////////
    // Command decode
    //////////////////////////////
    always @(posedge clock1 or negedge rst_n) begin
        if (!rst_n) begin
            refreshes   <= '0;
            earlyAccess <= 1'b0;
            badAccess   <= 1'b0;
            modeLoaded  <= 1'b0;
            rowOpen     <= 1'b0;
            rdOe        <= 1'b0;
            rdData      <= '0;
        end else begin
            rdOe <= 1'b0;  // Read word on dq for one cycle
            case (cmd)
                sdramPkg::LOAD_MODE: modeLoaded <= 1'b1;
                sdramPkg::REFRESH:   refreshes  <= refreshes + 1;
                sdramPkg::ACTIVE:    rowOpen    <= 1'b1;
                sdramPkg::PRECHARGE: rowOpen    <= 1'b0;
                sdramPkg::WRITE: begin
                    words[{ba, addr[8:0]}] <= dq;  // Data arrives with the command
                    if (!modeLoaded) earlyAccess <= 1'b1;
                    if (!rowOpen || dqm != 2'b00) badAccess <= 1'b1;
                end
                sdramPkg::READ: begin
                    rdOe   <= 1'b1;
                    rdData <= stuckEn ? forceBit(words[{ba, addr[8:0]}], stuckBit, stuckVal)
                                      : words[{ba, addr[8:0]}];
                    if (!modeLoaded) earlyAccess <= 1'b1;
                    if (!rowOpen) badAccess <= 1'b1;
                end
                default: ;  // NOP or deselect
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== dv/tbSdramTest.sv ====
`default_nettype none

`include "sdram_consts.svh"

module tbSdramTest;

    localparam int WaitLimit     = 4000;  // Cycles, init plus one full pass
    localparam int RefreshWindow = `SDRAM_REFRESH_INTERVAL + 50;

    logic        clock1;
    logic        rst_n;
    logic        stuckEn;
    logic [3:0]  stuckBit;
    logic        stuckVal;
    wire         cke, nCs, nRas, nCas, nWe;
    wire  [12:0] addr;
    wire  [1:0]  ba;
    wire  [1:0]  dqm;
    wire  [15:0] dq;
    wire         txd;
    wire         led;
    wire  [31:0] refreshes;
    wire         earlyAccess;
    wire         badAccess;
    logic        lastWrite;

    sdramPkg::report_s reports[$];  // From the UART receiver

    sdramTestTop uut (
        .clock1 (clock1), .rst_n (rst_n), .cke (cke), .nCs (nCs), .nRas (nRas),
        .nCas (nCas), .nWe (nWe), .addr (addr), .ba (ba), .dqm (dqm), .dq (dq),
        .txd (txd), .led (led)
    );

    sdramModel sdram (
        .clock1 (clock1), .rst_n (rst_n), .cke (cke), .nCs (nCs), .nRas (nRas),
        .nCas (nCas), .nWe (nWe), .addr (addr), .ba (ba), .dqm (dqm), .dq (dq),
        .stuckEn (stuckEn), .stuckBit (stuckBit), .stuckVal (stuckVal),
        .refreshes (refreshes), .earlyAccess (earlyAccess), .badAccess (badAccess)
    );

    always #50 clock1 = ~clock1;  // Period 100

    // WRITE to the last test word, end of a write phase
    assign lastWrite = cke && ({nCs, nRas, nCas, nWe} == sdramPkg::WRITE) &&
                       (addr[8:0] == 9'(`TEST_WORDS - 1));

    // Expected word n, LFSR taps 16 14 13 11 stepped n times from seed
    function automatic logic [15:0] patternAt(input int n);
        logic [15:0] lfsr;
        lfsr = `PATTERN_SEED;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
        return lfsr;
    endfunction

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic checkReport(input sdramPkg::report_s got, input sdramPkg::report_s exp,
                               input string what);
        if (got !== exp) begin
            abortRun($sformatf("FAIL at %0t: %s got pass %0d err %0d, expected pass %0d err %0d",
                               $time, what, got.passCount, got.errCount,
                               exp.passCount, exp.errCount));
        end
    endtask

    task automatic checkWord(input logic [15:0] got, input logic [15:0] exp, input string what);
        if (got !== exp) begin
            abortRun($sformatf("FAIL at %0t: %s got %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abortRun($sformatf("FAIL at %0t: %s got %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic waitReport(output sdramPkg::report_s r);
        int cycles;
        cycles = 0;
        while (reports.size() == 0) begin
            @(posedge clock1);
            cycles++;
            if (cycles > WaitLimit) abortRun("timeout waiting for a UART report");
        end
        r = reports.pop_front();
    endtask

    task automatic waitLastWrite();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clock1);
            cycles++;
            if (cycles > WaitLimit) abortRun("timeout waiting for the end of a write phase");
        end while (!lastWrite);
    endtask

    //////////////////////////////
    // UART receiver, mid-bit sampling
    //////////////////////////////
    initial begin : uartReceiver
        logic [19:0]       bits;
        int                idle;
        sdramPkg::report_s r;
        forever begin
            idle = 0;
            while (!(rst_n === 1'b1 && txd === 1'b0)) begin
                @(posedge clock1);
                idle++;
                if (idle > WaitLimit) abortRun("UART line stayed idle too long");
            end
            repeat (`UART_DIV / 2 - 1) @(posedge clock1);  // Centre of start bit
            for (int i = 0; i < 20; i++) begin
                bits[i] = txd;
                if (i < 19) repeat (`UART_DIV) @(posedge clock1);
            end
            if (bits[0] || !bits[9] || bits[10] || !bits[19]) begin
                abortRun("UART frame has a bad start or stop bit");
            end
            r.passCount = bits[8:1];   // First byte
            r.errCount  = bits[18:11];
            reports.push_back(r);
        end
    end

    // Refresh spacing and early access
    initial begin : refreshMonitor
        int gap;
        logic [31:0] seen;
        gap  = 0;
        seen = '0;
        forever begin
            @(posedge clock1);
            if (rst_n === 1'b1) begin
                if (refreshes != seen) begin
                    seen = refreshes;
                    gap  = 0;
                end else begin
                    gap++;
                end
                if (gap > RefreshWindow) abortRun("no SDRAM refresh within the refresh window");
                if (earlyAccess) abortRun("read or write reached the SDRAM before init ended");
                if (badAccess) abortRun("SDRAM access without an open row or with a mask");
            end
        end
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial begin : testSequence
        sdramPkg::report_s got;
        sdramPkg::report_s exp;
        integer            seed;
        logic [15:0]       word;
        int                expErr;
        logic [3:0]        bitSel;
        logic              valSel;
        seed     = 32'hb7926d91;
        clock1   = 1'b0;
        rst_n    = 1'b0;
        stuckEn  = 1'b0;
        stuckBit = '0;
        stuckVal = 1'b0;
        repeat (16) @(posedge clock1);
        rst_n <= 1'b1;
        @(posedge clock1);
        checkBit(txd, 1'b1, "txd after reset");
        checkBit(led, 1'b0, "led after reset");
        checkBit(cke, 1'b0, "cke after reset");

        // Clean first pass
        waitReport(got);
        exp.passCount = 8'd0;
        exp.errCount  = 8'd0;
        checkReport(got, exp, "first pass");
        for (int n = 0; n < `TEST_WORDS; n++) begin
            checkWord(sdram.words[n], patternAt(n), $sformatf("memory word %0d", n));
        end

        // Stuck bit over a whole read phase
        bitSel = 4'($random(seed));
        valSel = 1'($random(seed));
        expErr = 0;
        for (int n = 0; n < `TEST_WORDS; n++) begin
            word = patternAt(n);
            if (word[bitSel] != valSel) expErr++;
        end
        if (expErr > 255) expErr = 255;  // Saturates
        waitLastWrite();
        stuckEn  <= 1'b1;
        stuckBit <= bitSel;
        stuckVal <= valSel;
        waitReport(got);
        exp.passCount = 8'd1;
        exp.errCount  = 8'(expErr);
        checkReport(got, exp, "stuck bit pass");
        checkBit(led, expErr != 0, "led after stuck bit");

        // Fault removed, led holds
        waitLastWrite();
        stuckEn <= 1'b0;
        waitReport(got);
        exp.passCount = 8'd2;
        exp.errCount  = 8'd0;
        checkReport(got, exp, "pass after fault removed");
        checkBit(led, expErr != 0, "led stays latched");

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+common
common/sdramPkg.sv
common/memReqIf.sv
sdramCtrl/sdramCtrl.sv
hdl/patternGen.sv
hdl/memTester.sv
hdl/uartTx.sv
hdl/sdramTestTop.sv
dv/sdramModel.sv
dv/tbSdramTest.sv
